// File: compile.f
common/parking_pkg.sv
source/order_fifo.sv
elevator/slot_allocator.sv
elevator/slot_store.sv
elevator/elevator_fsm.sv
source/exit_report.sv
source/parking_lot_top.sv
bench/parking_lot_props.sv
bench/parking_lot_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= parking_lot_tb
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal -j 0
FILELIST  ?= compile.f

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'TB PASSED'

clean:
	rm -rf $(BUILD_DIR)

// File: bench/parking_lot_tb.sv
`timescale 1ns/100ps

module parking_lot_tb import parking_pkg::*; ();

    localparam int TOTAL_ORDERS    = 32;                 // 10 + 7 + 8 + 7 orders over all tests
    localparam int WATCHDOG_CYCLES = TOTAL_ORDERS * 40;

    logic        clock;
    logic        reset;
    logic        order_valid;
    plate_t      order_plate;
    logic        order_exit;
    logic        order_ready;
    logic        report_valid;
    logic        report_ready;
    plate_t      report_plate;
    status_t     report_status;
    slot_idx_t   report_slot;
    fee_t        report_fee;
    floor_t      current_floor;
    slot_count_t free_sedan;
    slot_count_t free_suv;

    plate_t      model_lot [NUM_SLOTS];      // Expected plate per slot, zero when empty
    int          model_stamp [NUM_SLOTS];    // Cycle of the parked record
    plate_t      exp_plates [$];             // Accepted orders still waiting for a record
    logic        exp_exits [$];
    logic [31:0] lcg_state = 32'hecac;
    logic [6:0]  serial = '0;
    int          check_count = 0;
    int          error_count = 0;
    int          errors_before = 0;
    int          cycle = 0;

    parking_lot_top #(.ORDER_DEPTH(4)) u_parking_lot_top (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Serial field keeps every plate unique and nonzero
    function automatic plate_t make_plate(input logic [3:0] cls, input logic suv);
        logic [31:0] r;
        r = next_random();
        serial = serial + 7'd1;
        return {cls, serial, r[19:16], suv};
    endfunction

    function automatic logic [3:0] regular_class();
        logic [31:0] r;
        r = next_random();
        return {1'b0, r[18:16]};
    endfunction

    function automatic int count_free(input logic suv_floors);
        int n;
        n = 0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (model_lot[i] == '0 && (((i / 2 + 1) % 2) == 1) == suv_floors)
                n++;
        end
        return n;
    endfunction

    // Expected record of one order, updates the model lot
    function automatic void reference_order(input plate_t p, input logic is_exit,
            input int stamp, output status_t st, output slot_idx_t sl, output fee_t fee);
        int   found;
        int   fl;
        int   cost;
        int   rate;
        logic odd_floor;
        logic sedan_full;
        st = STATUS_REJECTED;
        sl = '0;
        fee = '0;
        found = -1;
        sedan_full = (count_free(1'b0) == 0);
        for (int i = 0; i < NUM_SLOTS; i++) begin
            fl = i / 2 + 1;
            odd_floor = (fl % 2 == 1);
            if (found < 0 && p != '0) begin
                if (is_exit) begin
                    if (model_lot[i] == p)
                        found = i;
                end else if (model_lot[i] == '0
                        && (p[0] ? odd_floor : (!odd_floor || sedan_full))
                        && (p[15:12] == CLASS_HANDICAPPED || fl > 2 || i % 2 == 1)) begin
                    found = i;                          // Left places of floors 1 and 2
                end
            end
        end
        if (found >= 0) begin
            sl = slot_idx_t'(found);
            if (is_exit) begin
                rate = (p[15:12] == CLASS_HANDICAPPED) ? 0 : (p[15:12] == CLASS_HYBRID) ? 1 : 2;
                cost = rate * (stamp - model_stamp[found]);
                st = STATUS_LEFT;
                fee = (cost > 255) ? 8'hff : fee_t'(cost);
                model_lot[found] = '0;
            end else begin
                st = STATUS_PARKED;
                model_lot[found] = p;
                model_stamp[found] = stamp;
            end
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
            input logic [31:0] expected);
        check_count++;
        assert (got === expected) else begin
            $display("error %s: got %h, expected %h", name, got, expected);
            error_count++;
        end
    endtask

    task automatic check_free();
        check_value("free_sedan", 32'(free_sedan), 32'(count_free(1'b0)));
        check_value("free_suv", 32'(free_suv), 32'(count_free(1'b1)));
    endtask

    task automatic send_order(input plate_t p, input logic is_exit);
        @(negedge clock);
        order_valid = 1'b1;
        order_plate = p;
        order_exit  = is_exit;
        @(posedge clock);
        while (!order_ready)
            @(posedge clock);
        exp_plates.push_back(p);
        exp_exits.push_back(is_exit);
    endtask

    // Waits until every accepted order has its record
    task automatic drain_orders();
        @(negedge clock);
        order_valid = 1'b0;
        while (exp_plates.size() != 0)
            @(negedge clock);
    endtask

    task automatic report_test(input int num, input string name);
        $display("test %0d %s: %0d errors", num, name, error_count - errors_before);
        errors_before = error_count;
    endtask

    initial begin : compare_records
        status_t   exp_status;
        slot_idx_t exp_slot;
        fee_t      exp_fee;
        plate_t    exp_p;
        logic      exp_e;
        forever begin
            @(posedge clock);
            cycle++;
            if (report_valid && report_ready) begin
                check_count++;
                assert (exp_plates.size() != 0) else begin
                    $display("record for plate %h arrived with no order outstanding", report_plate);
                    error_count++;
                end
                if (exp_plates.size() != 0) begin
                    exp_p = exp_plates.pop_front();
                    exp_e = exp_exits.pop_front();
                    reference_order(exp_p, exp_e, cycle, exp_status, exp_slot, exp_fee);
                    check_value("report_plate", 32'(report_plate), 32'(exp_p));
                    check_value("report_status", 32'(report_status), 32'(exp_status));
                    check_value("report_slot", 32'(report_slot), 32'(exp_slot));
                    check_value("report_fee", 32'(report_fee), 32'(exp_fee));
                end
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("timeout: orders still unreported after %0d cycles", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    initial begin : stimulus
        plate_t      parked [10];
        plate_t      car;
        plate_t      car2;
        plate_t      held_plate;
        status_t     held_status;
        slot_idx_t   held_slot;
        fee_t        held_fee;
        logic [31:0] r;
        int          span;
        logic        saw_full;
        logic        held;
        reset        = 1'b1;
        order_valid  = 1'b0;
        order_plate  = '0;
        order_exit   = 1'b0;
        report_ready = 1'b1;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            model_lot[i]   = '0;
            model_stamp[i] = 0;
        end
        repeat (2) @(negedge clock);
        reset = 1'b0;

        @(negedge clock);
        check_value("report_valid", 32'(report_valid), 32'h0);
        check_value("order_ready", 32'(order_ready), 32'h1);
        check_value("current_floor", 32'(current_floor), 32'h0);
        check_free();
        report_test(1, "reset state");

        parked[0] = make_plate(regular_class(), 1'b1);      // Right place of floor 1
        parked[1] = make_plate(CLASS_HYBRID, 1'b1);
        parked[2] = make_plate(regular_class(), 1'b1);
        parked[3] = make_plate(CLASS_HYBRID, 1'b0);         // Right place of floor 2
        parked[4] = make_plate(regular_class(), 1'b0);
        parked[5] = make_plate(regular_class(), 1'b0);
        parked[6] = make_plate(CLASS_HYBRID, 1'b0);
        parked[7] = make_plate(regular_class(), 1'b0);
        parked[8] = make_plate(CLASS_HANDICAPPED, 1'b1);
        parked[9] = make_plate(CLASS_HANDICAPPED, 1'b0);
        for (int i = 0; i < 10; i++)
            send_order(parked[i], 1'b0);
        drain_orders();
        check_free();
        report_test(2, "allocation");

        // Sedan floors are full now
        send_order(make_plate(regular_class(), 1'b0), 1'b0);
        send_order(make_plate(regular_class(), 1'b1), 1'b0);
        send_order(make_plate(regular_class(), 1'b0), 1'b1);   // Plate never parked
        send_order(16'h0000, 1'b0);
        send_order(make_plate(CLASS_HANDICAPPED, 1'b1), 1'b0);
        send_order(make_plate(CLASS_HYBRID, 1'b0), 1'b0);
        send_order(make_plate(regular_class(), 1'b1), 1'b0);   // No slot left
        drain_orders();
        check_free();
        report_test(3, "overflow and rejection");

        car  = make_plate(regular_class(), 1'b1);
        car2 = make_plate(CLASS_HYBRID, 1'b0);
        send_order(parked[0], 1'b1);
        send_order(parked[3], 1'b1);
        send_order(parked[8], 1'b1);
        send_order(car, 1'b0);                                 // Reuses the freed slot
        send_order(car2, 1'b0);
        send_order(car, 1'b1);
        send_order(car2, 1'b1);
        send_order(car, 1'b1);                                 // Already gone
        drain_orders();
        check_free();
        report_test(4, "fees");

        r = next_random();
        span = 20 + int'(r[20:16]);
        saw_full = 1'b0;
        held = 1'b0;
        @(negedge clock);
        report_ready = 1'b0;
        fork
            begin
                for (int i = 0; i < 7; i++) begin
                    r = next_random();
                    send_order(make_plate(r[23:20], r[24]), 1'b0);
                end
            end
            begin
                repeat (span) begin
                    @(posedge clock);
                    if (!order_ready)
                        saw_full = 1'b1;
                    if (report_valid && !held) begin
                        held_plate  = report_plate;
                        held_status = report_status;
                        held_slot   = report_slot;
                        held_fee    = report_fee;
                        held        = 1'b1;
                    end else if (report_valid) begin
                        check_value("report_plate", 32'(report_plate), 32'(held_plate));
                        check_value("report_status", 32'(report_status), 32'(held_status));
                        check_value("report_slot", 32'(report_slot), 32'(held_slot));
                        check_value("report_fee", 32'(report_fee), 32'(held_fee));
                    end
                end
                @(negedge clock);
                report_ready = 1'b1;
            end
        join
        check_count++;
        assert (saw_full && held) else begin
            $display("order_ready never fell or no record was held while the report stalled");
            error_count++;
        end
        drain_orders();
        check_free();
        report_test(5, "back-pressure");

        $display("5 tests, %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

// File: bench/parking_lot_props.sv
`timescale 1ns/100ps

module parking_lot_props import parking_pkg::*; (
    input logic      clock,
    input logic      reset,
    input logic      report_valid,
    input logic      report_ready,
    input plate_t    report_plate,
    input status_t   report_status,
    input slot_idx_t report_slot,
    input fee_t      report_fee,
    input floor_t    current_floor,
    input logic      head_pop
);

    // A stalled record keeps all of its fields
    assert property (@(posedge clock) disable iff (reset)
        report_valid && !report_ready |=> report_valid && $stable(report_plate)
            && $stable(report_status) && $stable(report_slot) && $stable(report_fee))
        else $error("report record changed while report_ready was low");

    assert property (@(posedge clock) disable iff (reset)
        current_floor == $past(current_floor) || current_floor == $past(current_floor) + 3'd1
            || current_floor + 3'd1 == $past(current_floor))
        else $error("elevator moved more than one floor in a cycle");

    assert property (@(posedge clock) disable iff (reset) head_pop |-> current_floor == '0)
        else $error("order left the queue away from the lobby");   // Cars board at floor 0

endmodule

bind parking_lot_top parking_lot_props u_parking_lot_props (.*);

// File: source/parking_lot_top.sv
`timescale 1ns/100ps

module parking_lot_top import parking_pkg::*; #(
    parameter int ORDER_DEPTH = 4
) (
    input  logic        clock,
    input  logic        reset,
    input  logic        order_valid,
    input  plate_t      order_plate,
    input  logic        order_exit,
    output logic        order_ready,
    output logic        report_valid,
    input  logic        report_ready,
    output plate_t      report_plate,
    output status_t     report_status,
    output slot_idx_t   report_slot,
    output fee_t        report_fee,
    output floor_t      current_floor,
    output slot_count_t free_sedan,
    output slot_count_t free_suv
);
    logic      head_valid;
    plate_t    head_plate;
    logic      head_exit;
    logic      head_pop;
    plate_t    slot_plates [NUM_SLOTS];
    fee_t      slot_ages [NUM_SLOTS];
    logic      full_sedan;
    logic      store_en;
    logic      remove_en;
    slot_idx_t slot;
    plate_t    plate;
    logic      rec_load;
    plate_t    rec_plate;
    status_t   rec_status;
    slot_idx_t rec_slot;
    fee_t      rec_age;
    logic      rec_busy;

    // Input side
    order_fifo #(.ORDER_DEPTH(ORDER_DEPTH)) u_order_fifo (
        .clock, .reset,
        .order_valid, .order_plate, .order_exit, .order_ready,
        .head_valid, .head_plate, .head_exit, .head_pop
    );

    elevator_fsm u_elevator_fsm (
        .clock, .reset,
        .head_valid, .head_plate, .head_exit, .head_pop,
        .slot_plates, .full_sedan, .slot_ages, .rec_busy,
        .store_en, .remove_en, .slot, .plate,
        .rec_load, .rec_plate, .rec_status, .rec_slot, .rec_age,
        .current_floor
    );

    slot_store u_slot_store (
        .clock, .reset,
        .store_en, .remove_en, .slot, .plate,
        .slot_plates, .slot_ages, .free_sedan, .free_suv, .full_sedan
    );

    // Output side
    exit_report u_exit_report (
        .clock, .reset,
        .rec_load, .rec_plate, .rec_status, .rec_slot, .rec_age, .rec_busy,
        .report_valid, .report_ready,
        .report_plate, .report_status, .report_slot, .report_fee
    );

endmodule

// File: source/exit_report.sv
`timescale 1ns/100ps

module exit_report import parking_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      rec_load,
    input  plate_t    rec_plate,
    input  status_t   rec_status,
    input  slot_idx_t rec_slot,
    input  fee_t      rec_age,
    output logic      rec_busy,
    output logic      report_valid,
    input  logic      report_ready,
    output plate_t    report_plate,
    output status_t   report_status,
    output slot_idx_t report_slot,
    output fee_t      report_fee
);
    logic [9:0] fee_full;   // Rate times age before saturation
    fee_t       fee_next;

    assign fee_full = fee_rate(rec_plate) * rec_age;
    assign fee_next = (rec_status != STATUS_LEFT) ? '0
                    : (fee_full > 10'd255) ? 8'hff : fee_full[7:0];

    // A new record may replace one that leaves on the same edge
    assign rec_busy = report_valid && !report_ready;

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            report_valid <= 1'b0;
        else if (rec_load)
            report_valid <= 1'b1;
        else if (report_ready)
            report_valid <= 1'b0;
    end

    always_ff @(posedge clock) begin
        if (rec_load) begin
            report_plate  <= rec_plate;
            report_status <= rec_status;
            report_slot   <= rec_slot;
            report_fee    <= fee_next;
        end
    end

endmodule

// File: elevator/elevator_fsm.sv
`timescale 1ns/100ps

module elevator_fsm import parking_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      head_valid,
    input  plate_t    head_plate,
    input  logic      head_exit,
    output logic      head_pop,
    input  plate_t    slot_plates [NUM_SLOTS],
    input  logic      full_sedan,
    input  fee_t      slot_ages [NUM_SLOTS],
    input  logic      rec_busy,
    output logic      store_en,
    output logic      remove_en,
    output slot_idx_t slot,
    output plate_t    plate,
    output logic      rec_load,
    output plate_t    rec_plate,
    output status_t   rec_status,
    output slot_idx_t rec_slot,
    output fee_t      rec_age,
    output floor_t    current_floor
);
    elevator_state_t state;
    plate_t          order_plate;
    logic            order_exit;
    slot_idx_t       order_slot;
    floor_t          target_floor;
    logic            park_found;
    logic            exit_found;
    slot_idx_t       park_slot;
    slot_idx_t       exit_slot;
    logic            accept;       // Head order can be served

    slot_allocator u_slot_allocator (
        .plate       (head_plate),
        .slot_plates (slot_plates),
        .full_sedan  (full_sedan),
        .park_found  (park_found),
        .park_slot   (park_slot),
        .exit_found  (exit_found),
        .exit_slot   (exit_slot)
    );

    assign accept       = head_exit ? exit_found : (park_found && head_plate != '0);
    assign head_pop     = (state == ST_IDLE) && head_valid;
    assign target_floor = order_slot[3:1] + 3'd1;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state         <= ST_IDLE;
            current_floor <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    // A rejection with a free report register completes right here
                    if (head_pop && accept)
                        state <= ST_UP;
                    else if (head_pop && rec_busy)
                        state <= ST_REJECT;
                end
                ST_REJECT: begin
                    if (!rec_busy)
                        state <= ST_IDLE;
                end
                ST_UP: begin
                    current_floor <= current_floor + 3'd1;
                    if (current_floor + 3'd1 == target_floor)
                        state <= order_exit ? ST_FETCH : ST_STOW;
                end
                ST_STOW, ST_FETCH: begin
                    if (!rec_busy)
                        state <= ST_DOWN;  // Car waits on the platform while the report is full
                end
                ST_DOWN: begin
                    current_floor <= current_floor - 3'd1;
                    if (current_floor == 3'd1)
                        state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (head_pop) begin
            order_plate <= head_plate;
            order_exit  <= head_exit;
            order_slot  <= head_exit ? exit_slot : park_slot;
        end
    end

    assign store_en  = (state == ST_STOW) && !rec_busy;
    assign remove_en = (state == ST_FETCH) && !rec_busy;
    assign slot      = order_slot;
    assign plate     = order_plate;

    assign rec_load = store_en || remove_en
        || (state == ST_REJECT && !rec_busy)
        || (head_pop && !accept && !rec_busy);
    assign rec_plate = (state == ST_IDLE) ? head_plate : order_plate;
    assign rec_slot  = (state == ST_STOW || state == ST_FETCH) ? order_slot : '0;
    assign rec_age   = (state == ST_FETCH) ? slot_ages[order_slot] : '0;

    always_comb begin
        case (state)
            ST_STOW:  rec_status = STATUS_PARKED;
            ST_FETCH: rec_status = STATUS_LEFT;
            default:  rec_status = STATUS_REJECTED;
        endcase
    end

endmodule

// File: elevator/slot_store.sv
`timescale 1ns/100ps

module slot_store import parking_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        store_en,
    input  logic        remove_en,
    input  slot_idx_t   slot,
    input  plate_t      plate,
    output plate_t      slot_plates [NUM_SLOTS],
    output fee_t        slot_ages [NUM_SLOTS],
    output slot_count_t free_sedan,
    output slot_count_t free_suv,
    output logic        full_sedan
);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_SLOTS; i++)
                slot_plates[i] <= '0;
        end else begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                if (store_en && slot == slot_idx_t'(i))
                    slot_plates[i] <= plate;
                else if (remove_en && slot == slot_idx_t'(i))
                    slot_plates[i] <= '0;       // Zero plate marks the slot empty
            end
        end
    end

    // Age starts at 1 on the store edge and saturates
    always_ff @(posedge clock) begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (store_en && slot == slot_idx_t'(i))
                slot_ages[i] <= 8'd1;
            else if (slot_plates[i] != '0 && slot_ages[i] != 8'hff)
                slot_ages[i] <= slot_ages[i] + 8'd1;
        end
    end

    // Even floors hold sedans, odd floors hold SUVs
    always_comb begin
        free_sedan = '0;
        free_suv   = '0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (slot_plates[i] == '0) begin
                if (i[1])
                    free_sedan = free_sedan + slot_count_t'(1);
                else
                    free_suv = free_suv + slot_count_t'(1);
            end
        end
    end

    assign full_sedan = (free_sedan == '0);

endmodule

// File: elevator/slot_allocator.sv
`timescale 1ns/100ps

module slot_allocator import parking_pkg::*; (
    input  plate_t    plate,
    input  plate_t    slot_plates [NUM_SLOTS],
    input  logic      full_sedan,
    output logic      park_found,
    output slot_idx_t park_slot,
    output logic      exit_found,
    output slot_idx_t exit_slot
);
    logic                 handicapped;
    logic                 suv;
    logic [NUM_SLOTS-1:0] eligible;     // Empty and allowed for this car
    logic [NUM_SLOTS-1:0] holds_plate;

    // Index of the lowest set bit, zero when none is set
    function automatic slot_idx_t lowest_slot(input logic [NUM_SLOTS-1:0] vec);
        slot_idx_t idx;
        idx = '0;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (vec[i])
                idx = slot_idx_t'(i);
        end
        return idx;
    endfunction

    assign handicapped = (plate[15:12] == CLASS_HANDICAPPED);
    assign suv         = plate[0];

    // Bit 1 of the slot index is set on even floors (2, 4, 6)
    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            eligible[i] = (slot_plates[i] == '0)
                && (suv ? !i[1] : (i[1] || full_sedan))
                && (handicapped || i >= 4 || i[0]);   // Left places of floors 1 and 2
            holds_plate[i] = (plate != '0) && (slot_plates[i] == plate);
        end
    end

    // Every car enters at the lobby, so the lowest slot is also the nearest
    assign park_found = |eligible;
    assign park_slot  = lowest_slot(eligible);

    assign exit_found = |holds_plate;
    assign exit_slot  = lowest_slot(holds_plate);

endmodule

// File: source/order_fifo.sv
`timescale 1ns/100ps

module order_fifo import parking_pkg::*; #(
    parameter int ORDER_DEPTH = 4
) (
    input  logic   clock,
    input  logic   reset,
    input  logic   order_valid,
    input  plate_t order_plate,
    input  logic   order_exit,
    output logic   order_ready,
    output logic   head_valid,
    output plate_t head_plate,
    output logic   head_exit,
    input  logic   head_pop
);
    localparam int PTR_W = (ORDER_DEPTH > 1) ? $clog2(ORDER_DEPTH) : 1;
    localparam int CNT_W = $clog2(ORDER_DEPTH + 1);

    plate_t            plate_mem [ORDER_DEPTH];
    logic              exit_mem [ORDER_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              push;
    logic              pop;

    assign order_ready = (count != CNT_W'(ORDER_DEPTH));
    assign head_valid  = (count != '0);
    assign head_plate  = plate_mem[rd_ptr];
    assign head_exit   = exit_mem[rd_ptr];

    assign push = order_valid && order_ready;
    assign pop  = head_pop && head_valid;

    always_ff @(posedge clock) begin
        if (push) begin
            plate_mem[wr_ptr] <= order_plate;
            exit_mem[wr_ptr]  <= order_exit;
        end
    end

    // Pointers wrap at the depth, which need not be a power of two
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(ORDER_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(ORDER_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

endmodule

// File: common/parking_pkg.sv
package parking_pkg;

    typedef logic [15:0] plate_t;      // Class nibble on top, SUV flag at bit 0
    typedef logic [2:0]  floor_t;      // Floor 0 is the lobby
    typedef logic [3:0]  slot_idx_t;   // 2*(floor-1) + place, left is 0
    typedef logic [3:0]  slot_count_t;
    typedef logic [7:0]  fee_t;        // Also used for parking age
    typedef logic [1:0]  status_t;

    localparam int TOP_FLOOR = 7;
    localparam int NUM_SLOTS = 2 * TOP_FLOOR;

    localparam status_t STATUS_PARKED   = 2'd1;
    localparam status_t STATUS_LEFT     = 2'd2;
    localparam status_t STATUS_REJECTED = 2'd3;

    localparam logic [3:0] CLASS_HANDICAPPED = 4'h9;
    localparam logic [3:0] CLASS_HYBRID      = 4'h8;

    // Elevator sequencing states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_REJECT,
        ST_UP,
        ST_STOW,
        ST_FETCH,
        ST_DOWN
    } elevator_state_t;

    // Fee per cycle of parking, by plate class
    function automatic logic [1:0] fee_rate(input plate_t plate);
        if (plate[15:12] == CLASS_HANDICAPPED)
            return 2'd0;
        else if (plate[15:12] == CLASS_HYBRID)
            return 2'd1;
        return 2'd2;
    endfunction

endpackage
